// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module mipsCoreTb -Mdir obj_dir -o simv -f src.f
	./obj_dir/simv 2>&1 | tee sim.log
	@if grep -q "TEST FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "TEST PASSED" sim.log || (echo "no pass line in sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log

// ==== include/mipsCore_cfg.svh ====
`ifndef MIPS_CORE_CFG_SVH
`define MIPS_CORE_CFG_SVH

// datapath and register file geometry
`define CORE_DATA_W 32
`define CORE_REG_AW 5
`define CORE_REG_N  32

// primary opcodes
`define CORE_OP_SPECIAL 6'h00
`define CORE_OP_ADDI    6'h08
`define CORE_OP_ADDIU   6'h09
`define CORE_OP_SLTI    6'h0a
`define CORE_OP_SLTIU   6'h0b
`define CORE_OP_ANDI    6'h0c
`define CORE_OP_ORI     6'h0d
`define CORE_OP_XORI    6'h0e
`define CORE_OP_LUI     6'h0f

// funct codes under SPECIAL
`define CORE_FN_SLL  6'h00
`define CORE_FN_SRL  6'h02
`define CORE_FN_SRA  6'h03
`define CORE_FN_ADD  6'h20
`define CORE_FN_ADDU 6'h21
`define CORE_FN_SUB  6'h22
`define CORE_FN_SUBU 6'h23
`define CORE_FN_AND  6'h24
`define CORE_FN_OR   6'h25
`define CORE_FN_XOR  6'h26
`define CORE_FN_NOR  6'h27
`define CORE_FN_SLT  6'h2a
`define CORE_FN_SLTU 6'h2b

`endif

// ==== source/decodeStage.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "mipsCore_cfg.svh"

module decodeStage
    import mipsPkg::*;
(
    input  wire                          clk,
    input  wire                          arstN_i,
    input  wire                          instValid_i,
    input  wire     [31:0]               instr_i,
    output logic    [`CORE_REG_AW-1:0]   rdAddrA_o,
    output logic    [`CORE_REG_AW-1:0]   rdAddrB_o,
    input  wire     [`CORE_DATA_W-1:0]   rdDataA_i,
    input  wire     [`CORE_DATA_W-1:0]   rdDataB_i,
    input  wire     execRes_t            fwdExec_i,
    input  wire     regWrite_t           fwdWb_i,
    output execReq_t                     req_o
);

    logic [5:0]              opcode;
    logic [5:0]              funct;
    logic [`CORE_REG_AW-1:0] rs, rt, rd, dstReg;
    logic [4:0]              shamt;
    logic [15:0]             imm;
    logic [`CORE_DATA_W-1:0] immExt, opA, opB;
    aluOp_t                  aluOp;
    logic                    isImm, zeroExt, trapOvf, known;
    execReq_t                reqNext, reqPayload;
    logic                    reqValid, reqRegWrite;

    // newest in-flight value wins, r0 is never forwarded
    function automatic logic [`CORE_DATA_W-1:0] fwdValue(
        input logic [`CORE_REG_AW-1:0] addr,
        input logic [`CORE_DATA_W-1:0] rfData
    );
        logic [`CORE_DATA_W-1:0] value;
        value = rfData;
        if (addr != '0) begin
            if (fwdExec_i.valid && fwdExec_i.regWrite && !fwdExec_i.overflow &&
                fwdExec_i.writeReg == addr) begin
                value = fwdExec_i.aluOut;
            end else if (fwdWb_i.enable && fwdWb_i.writeReg == addr) begin
                value = fwdWb_i.data;
            end
        end
        return value;
    endfunction

    assign opcode = instr_i[31:26];
    assign rs     = instr_i[25:21];
    assign rt     = instr_i[20:16];
    assign rd     = instr_i[15:11];
    assign shamt  = instr_i[10:6];
    assign funct  = instr_i[5:0];
    assign imm    = instr_i[15:0];

    always_comb begin
        aluOp   = ALU_ADD;
        isImm   = 1'b1;
        zeroExt = 1'b0;
        trapOvf = 1'b0;
        known   = 1'b1;
        case (opcode)
            `CORE_OP_SPECIAL: begin
                isImm = 1'b0;
                case (funct)
                    `CORE_FN_ADDU: aluOp = ALU_ADD;
                    `CORE_FN_ADD: begin
                        aluOp   = ALU_ADD;
                        trapOvf = 1'b1;
                    end
                    `CORE_FN_SUBU: aluOp = ALU_SUB;
                    `CORE_FN_SUB: begin
                        aluOp   = ALU_SUB;
                        trapOvf = 1'b1;
                    end
                    `CORE_FN_AND:  aluOp = ALU_AND;
                    `CORE_FN_OR:   aluOp = ALU_OR;
                    `CORE_FN_XOR:  aluOp = ALU_XOR;
                    `CORE_FN_NOR:  aluOp = ALU_NOR;
                    `CORE_FN_SLT:  aluOp = ALU_SLT;
                    `CORE_FN_SLTU: aluOp = ALU_SLTU;
                    `CORE_FN_SLL:  aluOp = ALU_SLL;
                    `CORE_FN_SRL:  aluOp = ALU_SRL;
                    `CORE_FN_SRA:  aluOp = ALU_SRA;
                    default:       known = 1'b0;
                endcase
            end
            `CORE_OP_ADDIU: aluOp = ALU_ADD;
            `CORE_OP_ADDI: begin
                aluOp   = ALU_ADD;
                trapOvf = 1'b1;
            end
            `CORE_OP_SLTI:  aluOp = ALU_SLT;
            `CORE_OP_SLTIU: aluOp = ALU_SLTU; // sign extended, compared unsigned
            `CORE_OP_ANDI: begin
                aluOp   = ALU_AND;
                zeroExt = 1'b1;
            end
            `CORE_OP_ORI: begin
                aluOp   = ALU_OR;
                zeroExt = 1'b1;
            end
            `CORE_OP_XORI: begin
                aluOp   = ALU_XOR;
                zeroExt = 1'b1;
            end
            `CORE_OP_LUI:   aluOp = ALU_LUI;
            default:        known = 1'b0;
        endcase
    end

    assign immExt = zeroExt ? {{(`CORE_DATA_W-16){1'b0}}, imm}
                            : {{(`CORE_DATA_W-16){imm[15]}}, imm};
    assign dstReg = isImm ? rt : rd;

    assign rdAddrA_o = rs;
    assign rdAddrB_o = rt;
    assign opA       = fwdValue(rs, rdDataA_i);
    assign opB       = isImm ? immExt : fwdValue(rt, rdDataB_i);

    always_comb begin
        reqNext.valid          = instValid_i;
        reqNext.aluOp          = aluOp;
        reqNext.trapOnOverflow = trapOvf;
        reqNext.regWrite       = instValid_i && known && (dstReg != '0); // r0 writes dropped
        reqNext.writeReg       = dstReg;
        reqNext.shamt          = shamt;
        reqNext.srcA           = opA;
        reqNext.srcB           = opB;
    end

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            reqValid    <= 1'b0;
            reqRegWrite <= 1'b0;
        end else begin
            reqValid    <= reqNext.valid;
            reqRegWrite <= reqNext.regWrite;
        end
    end

    always_ff @(posedge clk) begin
        reqPayload <= reqNext;
    end

    always_comb begin
        req_o          = reqPayload;
        req_o.valid    = reqValid;
        req_o.regWrite = reqRegWrite;
    end

    // r0 must never show up on the writeback bundle
    assert property (@(posedge clk) disable iff (!arstN_i)
        fwdWb_i.enable |-> (fwdWb_i.writeReg != '0));

endmodule

`default_nettype wire

// ==== source/executeStage.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "mipsCore_cfg.svh"

module executeStage
    import mipsPkg::*;
(
    input  wire execReq_t req_i,
    output execRes_t      res_o
);

    localparam int HALF_W = `CORE_DATA_W / 2;

    logic [`CORE_DATA_W-1:0] sum, diff, aluOut;
    logic                    ovfAdd, ovfSub, ovf, isLogic;
    logic                    sltS, sltU;

    always_comb begin
        sum  = req_i.srcA + req_i.srcB;
        diff = req_i.srcA - req_i.srcB;
        // same-sign operands, result sign flipped
        ovfAdd = (req_i.srcA[`CORE_DATA_W-1] == req_i.srcB[`CORE_DATA_W-1]) &&
                 (sum[`CORE_DATA_W-1] != req_i.srcA[`CORE_DATA_W-1]);
        ovfSub = (req_i.srcA[`CORE_DATA_W-1] != req_i.srcB[`CORE_DATA_W-1]) &&
                 (diff[`CORE_DATA_W-1] != req_i.srcA[`CORE_DATA_W-1]);
        sltS = $signed(req_i.srcA) < $signed(req_i.srcB);
        sltU = req_i.srcA < req_i.srcB;

        case (req_i.aluOp)
            ALU_ADD:  aluOut = sum;
            ALU_SUB:  aluOut = diff;
            ALU_AND:  aluOut = req_i.srcA & req_i.srcB;
            ALU_OR:   aluOut = req_i.srcA | req_i.srcB;
            ALU_XOR:  aluOut = req_i.srcA ^ req_i.srcB;
            ALU_NOR:  aluOut = ~(req_i.srcA | req_i.srcB);
            ALU_SLT:  aluOut = {{(`CORE_DATA_W-1){1'b0}}, sltS};
            ALU_SLTU: aluOut = {{(`CORE_DATA_W-1){1'b0}}, sltU};
            ALU_SLL:  aluOut = req_i.srcB << req_i.shamt;
            ALU_SRL:  aluOut = req_i.srcB >> req_i.shamt;
            ALU_SRA:  aluOut = $signed(req_i.srcB) >>> req_i.shamt;
            ALU_LUI:  aluOut = {req_i.srcB[HALF_W-1:0], {HALF_W{1'b0}}};
            default:  aluOut = '0;
        endcase

        isLogic = (req_i.aluOp == ALU_AND) || (req_i.aluOp == ALU_OR) ||
                  (req_i.aluOp == ALU_XOR) || (req_i.aluOp == ALU_NOR);

        ovf = req_i.valid && req_i.trapOnOverflow &&
              ((req_i.aluOp == ALU_SUB) ? ovfSub : ovfAdd);

        res_o.valid    = req_i.valid;
        res_o.regWrite = req_i.regWrite;
        res_o.writeReg = req_i.writeReg;
        res_o.aluOut   = aluOut;
        res_o.overflow = ovf;

        // trap flag only comes with add and sub
        assert (!(ovf && isLogic))
            else $error("overflow raised on logical op %0d", req_i.aluOp);
    end

endmodule

`default_nettype wire

// ==== source/mipsCore.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "mipsCore_cfg.svh"

module mipsCore
    import mipsPkg::*;
(
    input  wire                        clk,
    input  wire                        arstN_i,
    input  wire                        instValid_i,
    input  wire  [31:0]                instr_i,
    output logic                       debugWbValid_o,
    output logic [3:0]                 debugWbRfWen_o,
    output logic [`CORE_REG_AW-1:0]    debugWbRfWnum_o,
    output logic [`CORE_DATA_W-1:0]    debugWbRfWdata_o,
    output logic                       overflow_o
);

    execReq_t                req;
    execRes_t                res;  // also the exec forwarding source
    regWrite_t               wb;
    logic [`CORE_REG_AW-1:0] rdAddrA, rdAddrB;
    logic [`CORE_DATA_W-1:0] rdDataA, rdDataB;

    decodeStage uDecode (
        .clk         (clk),
        .arstN_i     (arstN_i),
        .instValid_i (instValid_i),
        .instr_i     (instr_i),
        .rdAddrA_o   (rdAddrA),
        .rdAddrB_o   (rdAddrB),
        .rdDataA_i   (rdDataA),
        .rdDataB_i   (rdDataB),
        .fwdExec_i   (res),
        .fwdWb_i     (wb),
        .req_o       (req)
    );

    regFile uRegFile (
        .clk       (clk),
        .arstN_i   (arstN_i),
        .rdAddrA_i (rdAddrA),
        .rdAddrB_i (rdAddrB),
        .rdDataA_o (rdDataA),
        .rdDataB_o (rdDataB),
        .wr_i      (wb)
    );

    executeStage uExecute (
        .req_i (req),
        .res_o (res)
    );

    resultStage uResult (
        .clk              (clk),
        .arstN_i          (arstN_i),
        .res_i            (res),
        .wb_o             (wb),
        .debugWbValid_o   (debugWbValid_o),
        .debugWbRfWen_o   (debugWbRfWen_o),
        .debugWbRfWnum_o  (debugWbRfWnum_o),
        .debugWbRfWdata_o (debugWbRfWdata_o),
        .overflow_o       (overflow_o)
    );

endmodule

`default_nettype wire

// ==== source/mipsPkg.sv ====
`default_nettype none

`include "mipsCore_cfg.svh"

package mipsPkg;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_NOR  = 4'd5,
        ALU_SLT  = 4'd6,
        ALU_SLTU = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9,
        ALU_SRA  = 4'd10,
        ALU_LUI  = 4'd11
    } aluOp_t;

    // request registered at the end of decode
    typedef struct packed {
        logic                    valid;
        aluOp_t                  aluOp;
        logic                    trapOnOverflow; // add, sub, addi only
        logic                    regWrite;
        logic [`CORE_REG_AW-1:0] writeReg;
        logic [4:0]              shamt;
        logic [`CORE_DATA_W-1:0] srcA;
        logic [`CORE_DATA_W-1:0] srcB;           // immediate or rt value
    } execReq_t;

    // combinational ALU result
    typedef struct packed {
        logic                    valid;
        logic                    regWrite;
        logic [`CORE_REG_AW-1:0] writeReg;
        logic [`CORE_DATA_W-1:0] aluOut;
        logic                    overflow;
    } execRes_t;

    typedef struct packed {
        logic                    enable;
        logic [`CORE_REG_AW-1:0] writeReg;
        logic [`CORE_DATA_W-1:0] data;
    } regWrite_t;

endpackage

`default_nettype wire

// ==== source/regFile.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "mipsCore_cfg.svh"

module regFile
    import mipsPkg::*;
(
    input  wire                        clk,
    input  wire                        arstN_i,
    input  wire  [`CORE_REG_AW-1:0]    rdAddrA_i,
    input  wire  [`CORE_REG_AW-1:0]    rdAddrB_i,
    output logic [`CORE_DATA_W-1:0]    rdDataA_o,
    output logic [`CORE_DATA_W-1:0]    rdDataB_o,
    input  wire  regWrite_t            wr_i
);

    logic [`CORE_DATA_W-1:0] regs [`CORE_REG_N];

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            for (int i = 0; i < `CORE_REG_N; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_i.enable && (wr_i.writeReg != '0)) begin
            regs[wr_i.writeReg] <= wr_i.data;
        end
    end

    // async read, r0 hardwired
    assign rdDataA_o = (rdAddrA_i == '0) ? '0 : regs[rdAddrA_i];
    assign rdDataB_o = (rdAddrB_i == '0) ? '0 : regs[rdAddrB_i];

endmodule

`default_nettype wire

// ==== source/resultStage.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "mipsCore_cfg.svh"

module resultStage
    import mipsPkg::*;
(
    input  wire                        clk,
    input  wire                        arstN_i,
    input  wire  execRes_t             res_i,
    output regWrite_t                  wb_o,
    output logic                       debugWbValid_o,
    output logic [3:0]                 debugWbRfWen_o,
    output logic [`CORE_REG_AW-1:0]    debugWbRfWnum_o,
    output logic [`CORE_DATA_W-1:0]    debugWbRfWdata_o,
    output logic                       overflow_o
);

    logic                    validQ, wenQ, ovfQ;
    logic [`CORE_REG_AW-1:0] wnumQ;
    logic [`CORE_DATA_W-1:0] wdataQ;

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            validQ <= 1'b0;
            wenQ   <= 1'b0;
            ovfQ   <= 1'b0;
        end else begin
            validQ <= res_i.valid;
            wenQ   <= res_i.valid && res_i.regWrite && !res_i.overflow; // overflow kills write
            ovfQ   <= res_i.overflow;
        end
    end

    always_ff @(posedge clk) begin
        wnumQ  <= res_i.writeReg;
        wdataQ <= res_i.aluOut;
    end

    assign wb_o.enable   = wenQ;
    assign wb_o.writeReg = wnumQ;
    assign wb_o.data     = wdataQ;

    // trace port
    assign debugWbValid_o   = validQ;
    assign debugWbRfWen_o   = {4{wenQ}};
    assign debugWbRfWnum_o  = wnumQ;
    assign debugWbRfWdata_o = wdataQ;
    assign overflow_o       = ovfQ;

    assert property (@(posedge clk) disable iff (!arstN_i)
        overflow_o |-> debugWbValid_o);

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+include
source/mipsPkg.sv
source/regFile.sv
source/decodeStage.sv
source/executeStage.sv
source/resultStage.sv
source/mipsCore.sv
test/mipsCoreTb.sv

// ==== test/mipsCoreTb.sv ====
`default_nettype none
`timescale 1ns/10ps

module mipsCoreTb;

    localparam int unsigned SEED = 32'he27d57be;

    typedef struct packed {
        logic [31:0] cycle;  // cycle at which the writeback must show
        logic        valid;
        logic [3:0]  wen;
        logic [4:0]  wnum;
        logic [31:0] wdata;
        logic        ovf;
    } expected_t;

    typedef struct packed {
        logic        chain;  // issue right after the previous instruction
        logic [31:0] instr;
        expected_t   result;
    } caseLine_t;

    logic        clk = 1'b0;
    logic        arstN_i;
    logic        instValid_i;
    logic [31:0] instr_i;
    logic        debugWbValid_o;
    logic [3:0]  debugWbRfWen_o;
    logic [4:0]  debugWbRfWnum_o;
    logic [31:0] debugWbRfWdata_o;
    logic        overflow_o;

    caseLine_t   caseList[$];
    expected_t   expQ[$];
    expected_t   pending;
    expected_t   head;
    logic [31:0] cycle = '0;
    int          idx;
    int          idle;
    bit          loaded = 1'b0;

    mipsCore UUT (
        .clk              (clk),
        .arstN_i          (arstN_i),
        .instValid_i      (instValid_i),
        .instr_i          (instr_i),
        .debugWbValid_o   (debugWbValid_o),
        .debugWbRfWen_o   (debugWbRfWen_o),
        .debugWbRfWnum_o  (debugWbRfWnum_o),
        .debugWbRfWdata_o (debugWbRfWdata_o),
        .overflow_o       (overflow_o)
    );

    always #20 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 32'd1;

    task automatic checkField(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s expected %h actual %h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // one instruction per non-comment line
    task automatic loadCases();
        int          fd;
        int          count;
        string       line;
        int          chain;
        logic [31:0] instr, valid, wen, wnum, wdata, ovf;
        caseLine_t   rec;
        fd = $fopen("test/mipsCore_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open the case file test/mipsCore_cases.txt");
            $display("TEST FAILED");
            $fatal(1, "no case file");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 0 && line.substr(0, 0) != "#") begin
                    count = $sscanf(line, "%d %h %h %h %h %h %h",
                                    chain, instr, valid, wen, wnum, wdata, ovf);
                    if (count == 7) begin
                        rec.chain        = (chain != 0);
                        rec.instr        = instr;
                        rec.result.cycle = '0;
                        rec.result.valid = valid[0];
                        rec.result.wen   = wen[3:0];
                        rec.result.wnum  = wnum[4:0];
                        rec.result.wdata = wdata;
                        rec.result.ovf   = ovf[0];
                        caseList.push_back(rec);
                    end
                end
            end
            $fclose(fd);
            if (caseList.size() == 0) begin
                $display("the case file holds no instructions");
                $display("TEST FAILED");
                $fatal(1, "empty case file");
            end
        end
    endtask

    initial begin
        arstN_i     = 1'b0;
        instValid_i = 1'b0;
        instr_i     = '0;
        void'($urandom(SEED));
        loadCases();
        loaded = 1'b1;
        repeat (3) @(posedge clk);
        #2;
        arstN_i = 1'b1;

        for (idx = 0; idx < caseList.size(); idx++) begin
            if (idx != 0 && !caseList[idx].chain) begin
                idle = $urandom % 3;  // 0 to 2 bubbles
                repeat (idle) begin
                    @(posedge clk);
                    #2;
                    instValid_i = 1'b0;
                end
            end
            @(posedge clk);
            #2;
            instr_i       = caseList[idx].instr;
            instValid_i   = 1'b1;
            pending       = caseList[idx].result;
            pending.cycle = cycle + 32'd2;
            expQ.push_back(pending);
        end
        @(posedge clk);
        #2;
        instValid_i = 1'b0;

        while (expQ.size() != 0) @(posedge clk);
        repeat (4) @(posedge clk);  // room for a stray writeback

        $display("TEST PASSED");
        $finish;
    end

    // in-order checker, sampled away from the rising edge
    always @(negedge clk) begin
        if (arstN_i && (debugWbValid_o || (expQ.size() != 0 && expQ[0].cycle == cycle))) begin
            if (expQ.size() == 0) begin
                $display("writeback to register %0d seen with no instruction outstanding",
                         debugWbRfWnum_o);
                $display("TEST FAILED");
                $fatal(1, "spurious writeback");
            end else begin
                head = expQ.pop_front();
                checkField("debugWbValid_o", 32'(head.valid), 32'(debugWbValid_o));
                checkField("cycle", head.cycle, cycle);
                checkField("debugWbRfWen_o", 32'(head.wen), 32'(debugWbRfWen_o));
                checkField("debugWbRfWnum_o", 32'(head.wnum), 32'(debugWbRfWnum_o));
                // no defined data when nothing is written and nothing traps
                if (head.wen != 4'h0 || head.ovf) begin
                    checkField("debugWbRfWdata_o", head.wdata, debugWbRfWdata_o);
                end
                checkField("overflow_o", 32'(head.ovf), 32'(overflow_o));
            end
        end
    end

    // watchdog sized from the number of cases
    initial begin
        wait (loaded);
        #((caseList.size() * 4 + 20) * 40);
        $display("timeout after %0d cycles with %0d writebacks still outstanding",
                 caseList.size() * 4 + 20, expQ.size());
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// ==== test/mipsCore_cases.txt ====
# chain instr valid wen wnum wdata ovf, all hex except chain (decimal)
# chain 1 issues right after the previous line, wdata only checked on a write or overflow
0 24410005 1 f 01 00000005 0
0 34028001 1 f 02 00008001 0
0 3c038000 1 f 03 80000000 0
0 2404ffff 1 f 04 ffffffff 0
0 28850001 1 f 05 00000001 0
0 2c860001 1 f 06 00000000 0
0 30878f0f 1 f 07 00008f0f 0
0 3848ffff 1 f 08 00007ffe 0
0 00225021 1 f 0a 00008006 0
0 00225823 1 f 0b ffff8004 0
0 00876024 1 f 0c 00008f0f 0
0 00616825 1 f 0d 80000005 0
0 00487026 1 f 0e 0000ffff 0
0 00207827 1 f 0f fffffffa 0
0 0061802a 1 f 10 00000001 0
0 0061882b 1 f 11 00000000 0
0 00029100 1 f 12 00080010 0
0 00039a02 1 f 13 00800000 0
0 0003a203 1 f 14 ff800000 0
0 24150010 1 f 15 00000010 0
1 26b50001 1 f 15 00000011 0
1 02b5b021 1 f 16 00000022 0
1 24180100 1 f 18 00000100 0
1 24180200 1 f 18 00000200 0
1 0315c821 1 f 19 00000211 0
1 0316d023 1 f 1a 000001de 0
0 00636820 1 0 0d 00000000 1
1 01a0e025 1 f 1c 80000005 0
0 0061e822 1 0 1d 7ffffffb 1
1 207effff 1 0 1e 7fffffff 1
0 0063f821 1 f 1f 00000000 0
1 03bef825 1 f 1f 00000000 0
1 030de021 1 f 1c 80000205 0
0 24200007 1 0 00 00000000 0
1 00013021 1 f 06 00000005 0
0 fc070000 1 0 07 00000000 0
1 0000403f 1 0 08 00000000 0
1 00e84826 1 f 09 0000f0f1 0
0 00210021 1 0 00 00000000 0
